// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mesh
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+hdl
hdl/mesh_pkg.sv
hdl/msg_fifo.sv
hdl/mesh_node.sv
hdl/mesh_aggregator.sv
hdl/mesh_top.sv
verif/tb_clk_gen.sv
verif/tb_mesh.sv

// ==== hdl/mesh_aggregator.sv ====
// Column response collector that merges its column with the passthrough from the east
`timescale 1ns/1ns
`default_nettype none

module mesh_aggregator (
      input  logic                    i_clk
    , input  logic                    i_rst_n
    // Responses from the bottom of this column
    , input  mesh_pkg::node_message_t i_mesh_data
    , input  logic                    i_mesh_valid
    , output logic                    o_mesh_ready
    // Responses from the aggregator to the east
    , input  mesh_pkg::node_message_t i_thru_data
    , input  logic                    i_thru_valid
    , output logic                    o_thru_ready
    // Westward output
    , output mesh_pkg::node_message_t o_out_data
    , output logic                    o_out_valid
    , input  logic                    i_out_ready
);

import mesh_pkg::*;

node_message_t out_data_q;
logic          out_valid_q;
logic          out_free;
logic          prio_q;
logic          mesh_fire;
logic          thru_fire;

// prio_q low favours the column, high favours the passthrough
assign out_free     = !out_valid_q || i_out_ready;
assign o_mesh_ready = out_free && (!prio_q || !i_thru_valid);
assign o_thru_ready = out_free && (prio_q || !i_mesh_valid);

assign mesh_fire = i_mesh_valid && o_mesh_ready;
assign thru_fire = i_thru_valid && o_thru_ready;

// Winner hands priority to the other side
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        out_valid_q <= 1'b0;
        prio_q      <= 1'b0;
    end else if (mesh_fire) begin
        out_valid_q <= 1'b1;
        prio_q      <= 1'b1;
    end else if (thru_fire) begin
        out_valid_q <= 1'b1;
        prio_q      <= 1'b0;
    end else if (i_out_ready) begin
        out_valid_q <= 1'b0;
    end
end

always_ff @(posedge i_clk) begin
    if (mesh_fire) begin
        out_data_q <= i_mesh_data;
    end else if (thru_fire) begin
        out_data_q <= i_thru_data;
    end
end

assign o_out_data  = out_data_q;
assign o_out_valid = out_valid_q;

// Nodes only ever send responses down to the aggregators
a_mesh_resp_only: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_mesh_valid |-> (i_mesh_data.response.kind == RESPONSE));

a_thru_resp_only: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_thru_valid |-> (i_thru_data.response.kind == RESPONSE));

endmodule : mesh_aggregator

`default_nettype wire

// ==== hdl/mesh_node.sv ====
// Mesh routing node: buffered inbound ports, round-robin arbiter and a local data register
`timescale 1ns/1ns
`default_nettype none

`include "mesh_settings.svh"

module mesh_node (
      input  logic                          i_clk
    , input  logic                          i_rst_n
    , input  mesh_pkg::node_id_t            i_node_id
    // Inbound ports, indexed by direction
    , input  mesh_pkg::node_message_t [3:0] i_in_data
    , input  logic [3:0]                    i_in_valid
    , output logic [3:0]                    o_in_ready
    // Outbound ports, indexed by direction
    , output mesh_pkg::node_message_t [3:0] o_out_data
    , output logic [3:0]                    o_out_valid
    , input  logic [3:0]                    i_out_ready
);

import mesh_pkg::*;

// ==========================================================
// Inbound FIFOs
// ==========================================================

node_message_t [3:0] head_data;
logic [3:0]          head_valid;
logic [3:0]          head_ready;

generate
for (genvar idx = 0; idx < 4; idx++) begin : gen_fifos
    msg_fifo #(
          .DEPTH      ( `MESH_FIFO_DEPTH )
    ) u_fifo (
          .i_clk      ( i_clk            )
        , .i_rst_n    ( i_rst_n          )
        , .i_wr_data  ( i_in_data[idx]   )
        , .i_wr_valid ( i_in_valid[idx]  )
        , .o_wr_ready ( o_in_ready[idx]  )
        , .o_rd_data  ( head_data[idx]   )
        , .o_rd_valid ( head_valid[idx]  )
        , .i_rd_ready ( head_ready[idx]  )
    );
end
endgenerate

// ==========================================================
// Route decode and arbitration
// ==========================================================

logic [3:0]              out_valid_q;
node_message_t [3:0]     out_data_q;
logic [3:0]              out_free;
logic [3:0]              is_resp;
logic [3:0]              go_east;
logic [3:0]              go_south;
logic [3:0]              is_local;
logic [3:0]              need_south;
logic [3:0]              eligible;
logic [1:0]              rr_q;
logic [1:0]              gnt_idx;
logic                    gnt_valid;
logic [`MESH_DATA_W-1:0] data_q;

// An outbound register can take a message if empty or draining this cycle
assign out_free = ~out_valid_q | i_out_ready;

always_comb begin
    for (int idx = 0; idx < 4; idx++) begin
        is_resp[idx]  = (head_data[idx].request.kind == RESPONSE);
        go_east[idx]  = !is_resp[idx]
                     && (head_data[idx].request.target.column > i_node_id.column);
        go_south[idx] = !is_resp[idx] && !go_east[idx]
                     && (head_data[idx].request.target.row > i_node_id.row);
        is_local[idx] = !is_resp[idx] && !go_east[idx] && !go_south[idx];
        // Responses and locally answered queries both leave southward
        need_south[idx] = is_resp[idx] || go_south[idx]
                       || (is_local[idx] && (head_data[idx].request.kind == QUERY));
        eligible[idx] = head_valid[idx]
                     && (go_east[idx]    ? out_free[EAST]  :
                         need_south[idx] ? out_free[SOUTH] : 1'b1);
    end
end

// First eligible head at or after the round-robin pointer
always_comb begin
    gnt_idx   = rr_q;
    gnt_valid = 1'b0;
    for (int ofs = 3; ofs >= 0; ofs--) begin
        if (eligible[2'(rr_q + ofs)]) begin
            gnt_idx   = 2'(rr_q + ofs);
            gnt_valid = 1'b1;
        end
    end
end

assign head_ready = gnt_valid ? (4'b0001 << gnt_idx) : 4'b0000;

// ==========================================================
// Local consumption and outbound registers
// ==========================================================

node_message_t sel_msg;
node_message_t out_msg;
logic [3:0]    out_load;
logic          load_fire;

assign sel_msg   = head_data[gnt_idx];
assign load_fire = gnt_valid && is_local[gnt_idx] && (sel_msg.request.kind == LOAD);

// Replace a local query with its response
always_comb begin
    out_msg = sel_msg;
    if (is_local[gnt_idx] && (sel_msg.request.kind == QUERY)) begin
        out_msg.response.kind   = RESPONSE;
        out_msg.response.source = i_node_id;
        out_msg.response.spare  = '0;
        out_msg.response.value  = data_q;
    end
end

always_comb begin
    out_load        = 4'b0000;
    out_load[EAST]  = gnt_valid && go_east[gnt_idx];
    out_load[SOUTH] = gnt_valid && need_south[gnt_idx];
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        out_valid_q <= '0;
        rr_q        <= '0;
        data_q      <= '0;
    end else begin
        for (int idx = 0; idx < 4; idx++) begin
            if (out_load[idx]) out_valid_q[idx] <= 1'b1;
            else if (i_out_ready[idx]) out_valid_q[idx] <= 1'b0;
        end
        if (gnt_valid) rr_q <= gnt_idx + 1'b1;
        if (load_fire) data_q <= sel_msg.request.data;
    end
end

always_ff @(posedge i_clk) begin
    for (int idx = 0; idx < 4; idx++) begin
        if (out_load[idx]) out_data_q[idx] <= out_msg;
    end
end

assign o_out_data  = out_data_q;
assign o_out_valid = out_valid_q;

// Stalled outbound messages hold until taken
generate
for (genvar idx = 0; idx < 4; idx++) begin : gen_out_checks
    a_out_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_out_valid[idx] && !i_out_ready[idx]
        |=> o_out_valid[idx] && $stable(o_out_data[idx]));
end
endgenerate

endmodule : mesh_node

`default_nettype wire

// ==== hdl/mesh_pkg.sv ====
// Shared mesh types: node ids, message kinds, port directions and the message word
`default_nettype none

`include "mesh_settings.svh"

package mesh_pkg;

// Grid coordinate of a node
typedef struct packed {
    logic [`MESH_ROW_W-1:0] row;
    logic [`MESH_COL_W-1:0] column;
} node_id_t;

typedef enum logic [`MESH_KIND_W-1:0] {
      LOAD     = 'd0
    , QUERY    = 'd1
    , RESPONSE = 'd2
    , RESERVED = 'd3
} msg_kind_t;

// Port bundle index inside a node
typedef enum logic [1:0] {
      NORTH = 'd0
    , EAST  = 'd1
    , SOUTH = 'd2
    , WEST  = 'd3
} direction_t;

// Request as sent in from the ingress port
typedef struct packed {
    msg_kind_t                kind;
    node_id_t                 target;
    logic [`MESH_SPARE_W-1:0] spare;
    logic [`MESH_DATA_W-1:0]  data;
} node_request_t;

// Response heading out through the aggregators
typedef struct packed {
    msg_kind_t                kind;
    node_id_t                 source;
    logic [`MESH_SPARE_W-1:0] spare;
    logic [`MESH_DATA_W-1:0]  value;
} node_response_t;

// Kind sits at the top of both views
typedef union packed {
    node_request_t  request;
    node_response_t response;
} node_message_t;

endpackage : mesh_pkg

`default_nettype wire

// ==== hdl/mesh_settings.svh ====
// Build-time sizes for the message mesh: grid shape, FIFO depth and message fields

`ifndef MESH_SETTINGS_SVH
`define MESH_SETTINGS_SVH

// Grid shape
`define MESH_ROWS       3
`define MESH_COLS       3

// Depth of every node inbound FIFO
`define MESH_FIFO_DEPTH 2

// Message word and its fields
`define MESH_MSG_W      32
`define MESH_KIND_W     2
`define MESH_ROW_W      2
`define MESH_COL_W      2
`define MESH_SPARE_W    10
`define MESH_DATA_W     16

`endif

// ==== hdl/mesh_top.sv ====
// Message mesh top level: node grid, aggregator chain, ingress at node (0,0) and one egress
`timescale 1ns/1ns
`default_nettype none

`include "mesh_settings.svh"

module mesh_top (
      input  logic                    i_clk
    , input  logic                    i_rst_n
    // Ingress into node (0,0) north
    , input  mesh_pkg::node_message_t i_in_data
    , input  logic                    i_in_valid
    , output logic                    o_in_ready
    // Egress from aggregator 0
    , output mesh_pkg::node_message_t o_out_data
    , output logic                    o_out_valid
    , input  logic                    i_out_ready
);

import mesh_pkg::*;

// ==========================================================
// Node grid
// ==========================================================

// Outbound side of every node, indexed [row][column][direction]
node_message_t [`MESH_ROWS-1:0][`MESH_COLS-1:0][3:0] ob_data;
logic [`MESH_ROWS-1:0][`MESH_COLS-1:0][3:0]          ob_valid;
logic [`MESH_ROWS-1:0][`MESH_COLS-1:0][3:0]          ib_ready;
logic [`MESH_COLS-1:0]                               agg_mesh_ready;

generate
for (genvar idx_row = 0; idx_row < `MESH_ROWS; idx_row++) begin : gen_rows
    for (genvar idx_col = 0; idx_col < `MESH_COLS; idx_col++) begin : gen_cols

        localparam node_id_t NODE_ID = '{
            row:    `MESH_ROW_W'(idx_row),
            column: `MESH_COL_W'(idx_col)
        };

        node_message_t [3:0] ib_data;
        logic [3:0]          ib_valid;
        logic [3:0]          ob_ready;

        // North side, top row only takes the ingress at column 0
        if (idx_row == 0) begin : gen_north_edge
            assign ib_data[NORTH]  = (idx_col == 0) ? i_in_data : '0;
            assign ib_valid[NORTH] = (idx_col == 0) ? i_in_valid : 1'b0;
            assign ob_ready[NORTH] = 1'b0;
        end else begin : gen_north_link
            assign ib_data[NORTH]  = ob_data[idx_row-1][idx_col][SOUTH];
            assign ib_valid[NORTH] = ob_valid[idx_row-1][idx_col][SOUTH];
            assign ob_ready[NORTH] = ib_ready[idx_row-1][idx_col][SOUTH];
        end

        // South side, bottom row drains into the aggregator
        if (idx_row == `MESH_ROWS - 1) begin : gen_south_edge
            assign ib_data[SOUTH]  = '0;
            assign ib_valid[SOUTH] = 1'b0;
            assign ob_ready[SOUTH] = agg_mesh_ready[idx_col];
        end else begin : gen_south_link
            assign ib_data[SOUTH]  = ob_data[idx_row+1][idx_col][NORTH];
            assign ib_valid[SOUTH] = ob_valid[idx_row+1][idx_col][NORTH];
            assign ob_ready[SOUTH] = ib_ready[idx_row+1][idx_col][NORTH];
        end

        if (idx_col == `MESH_COLS - 1) begin : gen_east_edge
            assign ib_data[EAST]  = '0;
            assign ib_valid[EAST] = 1'b0;
            assign ob_ready[EAST] = 1'b0;
        end else begin : gen_east_link
            assign ib_data[EAST]  = ob_data[idx_row][idx_col+1][WEST];
            assign ib_valid[EAST] = ob_valid[idx_row][idx_col+1][WEST];
            assign ob_ready[EAST] = ib_ready[idx_row][idx_col+1][WEST];
        end

        if (idx_col == 0) begin : gen_west_edge
            assign ib_data[WEST]  = '0;
            assign ib_valid[WEST] = 1'b0;
            assign ob_ready[WEST] = 1'b0;
        end else begin : gen_west_link
            assign ib_data[WEST]  = ob_data[idx_row][idx_col-1][EAST];
            assign ib_valid[WEST] = ob_valid[idx_row][idx_col-1][EAST];
            assign ob_ready[WEST] = ib_ready[idx_row][idx_col-1][EAST];
        end

        mesh_node u_node (
              .i_clk       ( i_clk                      )
            , .i_rst_n     ( i_rst_n                    )
            , .i_node_id   ( NODE_ID                    )
            , .i_in_data   ( ib_data                    )
            , .i_in_valid  ( ib_valid                   )
            , .o_in_ready  ( ib_ready[idx_row][idx_col] )
            , .o_out_data  ( ob_data[idx_row][idx_col]  )
            , .o_out_valid ( ob_valid[idx_row][idx_col] )
            , .i_out_ready ( ob_ready                   )
        );

    end
end
endgenerate

assign o_in_ready = ib_ready[0][0][NORTH];

// ==========================================================
// Aggregator chain
// ==========================================================

// Entry MESH_COLS is the idle tail east of the last column
node_message_t [`MESH_COLS:0] agg_data;
logic [`MESH_COLS:0]          agg_valid;
logic [`MESH_COLS:0]          agg_ready;

assign agg_data[`MESH_COLS]  = '0;
assign agg_valid[`MESH_COLS] = 1'b0;

generate
for (genvar idx_col = 0; idx_col < `MESH_COLS; idx_col++) begin : gen_aggs
    mesh_aggregator u_agg (
          .i_clk        ( i_clk                                  )
        , .i_rst_n      ( i_rst_n                                )
        , .i_mesh_data  ( ob_data[`MESH_ROWS-1][idx_col][SOUTH]  )
        , .i_mesh_valid ( ob_valid[`MESH_ROWS-1][idx_col][SOUTH] )
        , .o_mesh_ready ( agg_mesh_ready[idx_col]                )
        , .i_thru_data  ( agg_data[idx_col+1]                    )
        , .i_thru_valid ( agg_valid[idx_col+1]                   )
        , .o_thru_ready ( agg_ready[idx_col+1]                   )
        , .o_out_data   ( agg_data[idx_col]                      )
        , .o_out_valid  ( agg_valid[idx_col]                     )
        , .i_out_ready  ( agg_ready[idx_col]                     )
    );
end
endgenerate

assign o_out_data   = agg_data[0];
assign o_out_valid  = agg_valid[0];
assign agg_ready[0] = i_out_ready;

endmodule : mesh_top

`default_nettype wire

// ==== hdl/msg_fifo.sv ====
// Circular message FIFO with a valid/ready write side and a valid/ready read side
`timescale 1ns/1ns
`default_nettype none

`include "mesh_settings.svh"

module msg_fifo #(
    parameter int DEPTH = 2
) (
      input  logic                    i_clk
    , input  logic                    i_rst_n
    // Write side
    , input  mesh_pkg::node_message_t i_wr_data
    , input  logic                    i_wr_valid
    , output logic                    o_wr_ready
    // Read side
    , output mesh_pkg::node_message_t o_rd_data
    , output logic                    o_rd_valid
    , input  logic                    i_rd_ready
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
        return '0;
    end
    return ptr + 1'b1;
endfunction

logic [`MESH_MSG_W-1:0] mem [DEPTH];
logic [PTR_W-1:0]       wr_ptr;
logic [PTR_W-1:0]       rd_ptr;
logic [CNT_W-1:0]       count;
logic                   wr_fire;
logic                   rd_fire;

// Ready comes from the fill level alone
assign o_wr_ready = (count != CNT_W'(DEPTH));
assign o_rd_valid = (count != '0);
assign o_rd_data  = mem[rd_ptr];

assign wr_fire = i_wr_valid && o_wr_ready;
assign rd_fire = o_rd_valid && i_rd_ready;

// Storage
always_ff @(posedge i_clk) begin
    if (wr_fire) begin
        mem[wr_ptr] <= i_wr_data;
    end
end

// Pointers and fill level
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (wr_fire) wr_ptr <= ptr_inc(wr_ptr);
        if (rd_fire) rd_ptr <= ptr_inc(rd_ptr);
        case ({wr_fire, rd_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

// Full means the write pointer has wrapped round onto the read pointer
a_full_ptr_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (count == CNT_W'(DEPTH)) |-> (wr_ptr == rd_ptr));

// Empty means the read pointer has caught up with the write pointer
a_empty_ptr_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (count == '0) |-> (wr_ptr == rd_ptr));

endmodule : msg_fifo

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and reset source with a free-running clock and a short reset pulse
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
      parameter int PERIOD_NS    = 40
    , parameter int RESET_CYCLES = 5
) (
      output logic o_clk
    , output logic o_rst_n
);

initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
end

// Release lands just after an edge, clear of the sampling point
initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2;
    o_rst_n = 1'b1;
end

endmodule : tb_clk_gen

`default_nettype wire

// ==== verif/tb_mesh.sv ====
// Message mesh testbench: ingress stimulus, reference register model and egress checker
`timescale 1ns/1ns
`default_nettype none

`include "mesh_settings.svh"

module tb_mesh;

import mesh_pkg::*;

localparam int NODES          = `MESH_ROWS * `MESH_COLS;
localparam int SEND_TIMEOUT   = 200;
localparam int DRAIN_TIMEOUT  = 2000;
localparam int QUIET_CYCLES   = 40;

logic                   clk;
logic                   rst_n;
node_message_t          in_data;
logic                   in_valid;
logic                   in_ready;
node_message_t          out_data;
logic                   out_valid;
logic                   out_ready;

logic [`MESH_DATA_W-1:0] model_regs [NODES];
logic [`MESH_MSG_W-1:0]  exp_q [NODES][$];
int                      seed;
int                      ready_seed;
logic [31:0]             ready_word;
logic                    rand_ready;
logic                    prev_stall;
node_message_t           prev_data;
int                      stall_cycles;
int                      rx_count;
int                      errors;
int                      tests_passed;
int                      tests_failed;

tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

mesh_top dut (
      .i_clk       ( clk       )
    , .i_rst_n     ( rst_n     )
    , .i_in_data   ( in_data   )
    , .i_in_valid  ( in_valid  )
    , .o_in_ready  ( in_ready  )
    , .o_out_data  ( out_data  )
    , .o_out_valid ( out_valid )
    , .i_out_ready ( out_ready )
);

// ============================================================
// Reference model
// ============================================================

function automatic int node_index(input node_id_t id);
    return int'(id.row) * `MESH_COLS + int'(id.column);
endfunction

function automatic node_message_t make_msg(input msg_kind_t kind, input int row, input int col,
                                           input logic [`MESH_DATA_W-1:0] data);
    node_message_t msg;
    msg = '0;
    msg.request.kind          = kind;
    msg.request.target.row    = `MESH_ROW_W'(row);
    msg.request.target.column = `MESH_COL_W'(col);
    msg.request.data          = data;
    return msg;
endfunction

// Response a query to this node should bring back, from the model
function automatic logic [`MESH_MSG_W-1:0] expected_response(input node_id_t target);
    node_message_t rsp;
    rsp = '0;
    rsp.response.kind   = RESPONSE;
    rsp.response.source = target;
    rsp.response.value  = model_regs[node_index(target)];
    return rsp;
endfunction

function automatic int pending_count();
    int total;
    total = 0;
    for (int idx = 0; idx < NODES; idx++) total += exp_q[idx].size();
    return total;
endfunction

// Model follows each accepted request in ingress order
task automatic note_request(input node_message_t msg);
    if (msg.request.kind == LOAD) begin
        model_regs[node_index(msg.request.target)] = msg.request.data;
    end else if (msg.request.kind == QUERY) begin
        exp_q[node_index(msg.request.target)].push_back(expected_response(msg.request.target));
    end
endtask

// ============================================================
// Stimulus helpers
// ============================================================

task automatic step();
    @(posedge clk);
    #2;
endtask

// Entered 2 ns after an edge, returns the same way
task automatic send_msg(input node_message_t msg);
    int waited;
    waited   = 0;
    in_data  = msg;
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready && waited < SEND_TIMEOUT) begin
        waited++;
        @(negedge clk);
    end
    if (in_ready) begin
        note_request(msg);
    end else begin
        $display("Error at %0t: ingress never accepted message %08h", $time, msg);
        errors++;
    end
    step();
    in_valid = 1'b0;
endtask

task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending_count() != 0 && waited < DRAIN_TIMEOUT) begin
        @(posedge clk);
        waited++;
    end
    if (pending_count() != 0) begin
        $display("Error at %0t: %0d responses never arrived", $time, pending_count());
        errors++;
        for (int idx = 0; idx < NODES; idx++) exp_q[idx].delete();
    end
endtask

task automatic finish_test(input string name, input int err_start);
    if (errors == err_start) begin
        tests_passed++;
        $display("Test %s: passed", name);
    end else begin
        tests_failed++;
        $display("Test %s: failed with %0d errors", name, errors - err_start);
    end
endtask

// Random egress back-pressure, about three cycles in four ready
always @(posedge clk) begin
    #2;
    if (rand_ready) begin
        ready_word = $random(ready_seed);
        out_ready  = ready_word[0] | ready_word[1];
    end
end

// ============================================================
// Egress checker, sampled mid-cycle
// ============================================================

always @(negedge clk) begin : egress_check
    int                     src;
    logic [`MESH_MSG_W-1:0] exp_word;
    if (!rst_n) begin
        prev_stall = 1'b0;
    end else begin
        if (prev_stall && !out_valid) begin
            $display("Fail at %0t: o_out_valid expected 1 got 0", $time);
            errors++;
        end else if (prev_stall && out_data != prev_data) begin
            $display("Fail at %0t: o_out_data expected %08h got %08h", $time, prev_data, out_data);
            errors++;
        end
        if (out_valid && out_ready) begin
            rx_count++;
            src = node_index(out_data.response.source);
            if (out_data.response.source.row >= `MESH_ROWS
                    || out_data.response.source.column >= `MESH_COLS
                    || exp_q[src].size() == 0) begin
                $display("Error at %0t: unexpected egress message %08h", $time, out_data);
                errors++;
            end else begin
                exp_word = exp_q[src].pop_front();
                if (out_data != exp_word) begin
                    $display("Fail at %0t: o_out_data expected %08h got %08h",
                             $time, exp_word, out_data);
                    errors++;
                end
            end
        end
        prev_stall = out_valid && !out_ready;
        prev_data  = out_data;
        if (prev_stall) stall_cycles++;
    end
end

// ============================================================
// Test sequence
// ============================================================

initial begin
    int          err_start;
    int          waited;
    int          rx_before;
    int          row;
    int          col;
    logic [31:0] rnd;
    logic [31:0] rnd_data;
    seed         = 32'h0340487a;
    ready_seed   = seed ^ 32'h5a5a5a5a;
    in_data      = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b1;
    rand_ready   = 1'b0;
    prev_stall   = 1'b0;
    prev_data    = '0;
    stall_cycles = 0;
    rx_count     = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int idx = 0; idx < NODES; idx++) model_regs[idx] = '0;

    waited = 0;
    while (rst_n !== 1'b1 && waited < 20) begin
        @(posedge clk);
        waited++;
    end
    if (rst_n !== 1'b1) begin
        $display("Error at %0t: reset was never released", $time);
        errors++;
    end

    // Registers read back zero after reset
    err_start = errors;
    step();
    // Idle state straight after reset
    if (in_ready !== 1'b1) begin
        $display("Fail at %0t: o_in_ready expected 1 got %b", $time, in_ready);
        errors++;
    end
    if (out_valid !== 1'b0) begin
        $display("Fail at %0t: o_out_valid expected 0 got %b", $time, out_valid);
        errors++;
    end
    for (int r = 0; r < `MESH_ROWS; r++)
        for (int c = 0; c < `MESH_COLS; c++) send_msg(make_msg(QUERY, r, c, '0));
    wait_drain();
    finish_test("1 query after reset", err_start);

    err_start = errors;
    step();
    for (int r = 0; r < `MESH_ROWS; r++) begin
        for (int c = 0; c < `MESH_COLS; c++) begin
            rnd_data = $random(seed);
            send_msg(make_msg(LOAD, r, c, rnd_data[15:0]));
        end
    end
    for (int r = 0; r < `MESH_ROWS; r++)
        for (int c = 0; c < `MESH_COLS; c++) send_msg(make_msg(QUERY, r, c, '0));
    wait_drain();
    finish_test("2 load then query", err_start);

    // Dropped message must neither answer nor touch the register
    err_start = errors;
    step();
    send_msg(make_msg(RESERVED, 1, 2, 16'hdead));
    send_msg(make_msg(QUERY, 1, 2, '0));
    wait_drain();
    rx_before = rx_count;
    for (int cyc = 0; cyc < QUIET_CYCLES; cyc++) @(posedge clk);
    if (rx_count != rx_before) begin
        $display("Error at %0t: extra egress message after the query response", $time);
        errors++;
    end
    finish_test("3 reserved dropped", err_start);

    err_start = errors;
    step();
    out_ready = 1'b0;
    stall_cycles = 0;
    for (int r = 0; r < `MESH_ROWS; r++)
        for (int c = 0; c < `MESH_COLS; c++) send_msg(make_msg(QUERY, r, c, '0));
    for (int cyc = 0; cyc < 30; cyc++) @(posedge clk);
    if (stall_cycles == 0) begin
        $display("Error at %0t: egress never stalled while ready was low", $time);
        errors++;
    end
    step();
    out_ready = 1'b1;
    wait_drain();
    finish_test("4 egress back-pressure", err_start);

    err_start = errors;
    @(negedge clk);
    rand_ready = 1'b1;
    step();
    for (int n = 0; n < 60; n++) begin
        rnd      = $random(seed);
        rnd_data = $random(seed);
        row      = int'(rnd[15:0]) % `MESH_ROWS;
        col      = int'(rnd[31:16]) % `MESH_COLS;
        send_msg(make_msg(rnd[20] ? QUERY : LOAD, row, col, rnd_data[15:0]));
    end
    @(negedge clk);
    rand_ready = 1'b0;
    step();
    out_ready = 1'b1;
    wait_drain();
    finish_test("5 random burst", err_start);

    $display("Summary: %0d tests passed, %0d failed, %0d errors, %0d responses",
             tests_passed, tests_failed, errors, rx_count);
    if (errors == 0 && tests_failed == 0) begin
        $display("PASS: all tests");
    end else begin
        $display("FAIL: see errors above");
    end
    $finish;
end

endmodule : tb_mesh

`default_nettype wire
